/* source/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Start address after reset
`define RV_RESET_PC 32'h0000_0000

// Major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
// ECALL lives here and halts the core
`define OPC_SYSTEM  7'b1110011

// funct3 codes
`define F3_ADD_SUB  3'b000
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000

// addi x0, x0, 0
`define RV_BUBBLE   32'h0000_0013

`endif

/* source/rv_pkg.sv */
`include "rv_settings.svh"

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // Operand source for the instruction in X
  typedef enum logic [1:0] {
    FWD_NONE      = 2'b00,
    FWD_ONE_CYCLE = 2'b01,
    FWD_TWO_CYCLE = 2'b10
  } fwd_sel_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_SETUP,
    ARB_ACCESS
  } arb_state_t;

  function automatic opcode_t opcode_of(word_t inst);
    return inst[6:0];
  endfunction

  function automatic reg_idx_t rd_of(word_t inst);
    return inst[11:7];
  endfunction

  function automatic reg_idx_t rs1_of(word_t inst);
    return inst[19:15];
  endfunction

  function automatic reg_idx_t rs2_of(word_t inst);
    return inst[24:20];
  endfunction

  // Stores and branches carry no rd
  function automatic logic is_producer(word_t inst);
    return !(inst[6:0] == `OPC_STORE || inst[6:0] == `OPC_BRANCH);
  endfunction

endpackage

/* source/forwarding_logic.sv */
`timescale 1ns/1ns

module forwarding_logic (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall,
  input  rv_pkg::word_t    fd_instruction,
  input  rv_pkg::word_t    x_instruction,
  input  rv_pkg::word_t    m_instruction,
  output rv_pkg::fwd_sel_t a_forward_select,
  output rv_pkg::fwd_sel_t b_forward_select
);
  import rv_pkg::*;

  reg_idx_t x_rd;
  reg_idx_t m_rd;
  reg_idx_t fd_rs1;
  reg_idx_t fd_rs2;
  logic     x_produces;
  logic     m_produces;
  fwd_sel_t a_sel_next;
  fwd_sel_t b_sel_next;

  // Nearer producer wins, x0 never matches
  function automatic fwd_sel_t select_for(reg_idx_t rs, logic x_prod, reg_idx_t x_dst,
                                          logic m_prod, reg_idx_t m_dst);
    if (rs == '0) begin
      return FWD_NONE;
    end
    if (x_prod && x_dst == rs) begin
      return FWD_ONE_CYCLE;
    end
    if (m_prod && m_dst == rs) begin
      return FWD_TWO_CYCLE;
    end
    return FWD_NONE;
  endfunction

  // --------------------------------------------------
  // Hazard compare against the FD instruction
  // --------------------------------------------------
  assign x_rd       = rd_of(x_instruction);
  assign m_rd       = rd_of(m_instruction);
  assign fd_rs1     = rs1_of(fd_instruction);
  assign fd_rs2     = rs2_of(fd_instruction);
  assign x_produces = is_producer(x_instruction);
  assign m_produces = is_producer(m_instruction);

  always_comb begin
    a_sel_next = select_for(fd_rs1, x_produces, x_rd, m_produces, m_rd);
    b_sel_next = select_for(fd_rs2, x_produces, x_rd, m_produces, m_rd);
  end

  // Loaded as FD moves into X, so valid while that instruction sits in X
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_forward_select <= FWD_NONE;
      b_forward_select <= FWD_NONE;
    end else if (!stall) begin
      a_forward_select <= a_sel_next;
      b_forward_select <= b_sel_next;
    end
  end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ns
`include "rv_settings.svh"

module fetch_unit (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          stall,
  input  logic          branch_taken,
  input  rv_pkg::word_t branch_target,
  output logic          fetch_req,
  output rv_pkg::word_t fetch_addr,
  input  logic          fetch_done,
  input  rv_pkg::word_t fetch_rdata,
  output rv_pkg::word_t fd_instruction,
  output rv_pkg::word_t fd_pc,
  output logic          fd_valid,
  output logic          halted
);
  import rv_pkg::*;

  word_t pc;
  logic  drop;
  logic  halting;
  logic  ecall_in_x;
  logic  advance;
  logic  capture;

  assign advance = !stall;
  // A fetch that was in flight across a taken branch is thrown away
  assign capture = fetch_done && !drop && !branch_taken;

  // --------------------------------------------------
  // PC and FD slot
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc             <= `RV_RESET_PC;
      fd_instruction <= `RV_BUBBLE;
      fd_pc          <= `RV_RESET_PC;
      fd_valid       <= 1'b0;
      halting        <= 1'b0;
      ecall_in_x     <= 1'b0;
      halted         <= 1'b0;
    end else if (branch_taken) begin
      pc             <= branch_target;
      fd_instruction <= `RV_BUBBLE;
      fd_valid       <= 1'b1;
      halting        <= 1'b0;
      ecall_in_x     <= 1'b0;
    end else if (capture) begin
      pc             <= fetch_addr + 32'd4;
      fd_instruction <= fetch_rdata;
      fd_pc          <= fetch_addr;
      fd_valid       <= 1'b1;
      halting        <= (opcode_of(fetch_rdata) == `OPC_SYSTEM);
    end else if (advance) begin
      // Bubbles drain the older instructions behind an ECALL
      fd_instruction <= `RV_BUBBLE;
      fd_valid       <= halting;
      if (halting) begin
        ecall_in_x <= 1'b1;
        halted     <= halted || ecall_in_x;
      end
    end
  end

  // --------------------------------------------------
  // Fetch request, held until done
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_req  <= 1'b0;
      fetch_addr <= `RV_RESET_PC;
      drop       <= 1'b0;
    end else if (fetch_req) begin
      if (fetch_done) begin
        fetch_req <= 1'b0;
        drop      <= 1'b0;
      end else if (branch_taken) begin
        drop <= 1'b1;
      end
    end else if ((!fd_valid || advance) && !halting && !branch_taken) begin
      fetch_req  <= 1'b1;
      fetch_addr <= pc;
    end
  end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ns
`include "rv_settings.svh"

module execute_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             fd_valid,
  input  rv_pkg::word_t    fd_instruction,
  input  rv_pkg::word_t    fd_pc,
  input  rv_pkg::fwd_sel_t a_forward_select,
  input  rv_pkg::fwd_sel_t b_forward_select,
  output rv_pkg::word_t    x_instruction,
  output rv_pkg::word_t    m_instruction,
  output logic             stall,
  output logic             branch_taken,
  output rv_pkg::word_t    branch_target,
  output logic             data_req,
  output logic             data_we,
  output rv_pkg::word_t    data_addr,
  output rv_pkg::word_t    data_wdata,
  input  logic             data_done,
  input  rv_pkg::word_t    data_rdata
);
  import rv_pkg::*;

  word_t      regs [32];
  word_t      x_pc;
  word_t      x_rs1_val;
  word_t      x_rs2_val;
  logic       x_resolved;
  opcode_t    x_opcode;
  logic [2:0] x_funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      op_a;
  word_t      op_b;
  word_t      alu_result;
  word_t      m_result;
  word_t      m_store_data;
  word_t      m_value;
  word_t      wb_value;
  reg_idx_t   m_rd;
  logic       m_is_load;
  logic       m_is_mem;
  logic       m_mem_done;
  logic       m_wait;

  function automatic word_t operand_mux(fwd_sel_t sel, word_t rf_val, word_t m_val,
                                        word_t wb_val);
    case (sel)
      FWD_ONE_CYCLE: return m_val;
      FWD_TWO_CYCLE: return wb_val;
      default:       return rf_val;
    endcase
  endfunction

  // --------------------------------------------------
  // X stage
  // --------------------------------------------------
  assign x_opcode = opcode_of(x_instruction);
  assign x_funct3 = x_instruction[14:12];
  assign imm_i    = {{20{x_instruction[31]}}, x_instruction[31:20]};
  assign imm_s    = {{20{x_instruction[31]}}, x_instruction[31:25], x_instruction[11:7]};
  assign imm_b    = {{19{x_instruction[31]}}, x_instruction[31], x_instruction[7],
                     x_instruction[30:25], x_instruction[11:8], 1'b0};

  assign op_a = operand_mux(a_forward_select, x_rs1_val, m_value, wb_value);
  assign op_b = operand_mux(b_forward_select, x_rs2_val, m_value, wb_value);

  always_comb begin
    case (x_opcode)
      `OPC_OP: begin
        case (x_funct3)
          `F3_ADD_SUB: alu_result = x_instruction[30] ? op_a - op_b : op_a + op_b;
          `F3_XOR:     alu_result = op_a ^ op_b;
          `F3_OR:      alu_result = op_a | op_b;
          `F3_AND:     alu_result = op_a & op_b;
          default:     alu_result = '0;
        endcase
      end
      `OPC_OP_IMM, `OPC_LOAD: alu_result = op_a + imm_i;
      `OPC_STORE:             alu_result = op_a + imm_s;
      default:                alu_result = '0;
    endcase
  end

  // Resolved once, and not while a load result is still missing
  assign branch_taken  = (x_opcode == `OPC_BRANCH) && (x_funct3 == `F3_BEQ) &&
                         (op_a == op_b) && !x_resolved && !m_wait;
  assign branch_target = x_pc + imm_b;

  // --------------------------------------------------
  // M stage and stall
  // --------------------------------------------------
  assign m_rd       = rd_of(m_instruction);
  assign m_is_load  = (opcode_of(m_instruction) == `OPC_LOAD);
  assign data_we    = (opcode_of(m_instruction) == `OPC_STORE);
  assign m_is_mem   = m_is_load || data_we;
  assign m_wait     = m_is_mem && !m_mem_done && !data_done;
  assign m_value    = (m_is_load && data_done) ? data_rdata : m_result;
  assign data_req   = m_is_mem && !m_mem_done;
  assign data_addr  = m_result;
  assign data_wdata = m_store_data;

  assign stall = m_wait || !fd_valid || branch_taken;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_instruction <= `RV_BUBBLE;
      x_resolved    <= 1'b0;
      m_instruction <= `RV_BUBBLE;
      m_mem_done    <= 1'b0;
    end else if (!stall) begin
      x_instruction <= fd_instruction;
      x_resolved    <= 1'b0;
      m_instruction <= x_instruction;
      m_mem_done    <= 1'b0;
    end else begin
      if (branch_taken) begin
        x_resolved <= 1'b1;
      end
      if (data_done) begin
        m_mem_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      x_pc         <= fd_pc;
      x_rs1_val    <= (rs1_of(fd_instruction) == '0) ? '0 : regs[rs1_of(fd_instruction)];
      x_rs2_val    <= (rs2_of(fd_instruction) == '0) ? '0 : regs[rs2_of(fd_instruction)];
      m_result     <= alu_result;
      m_store_data <= op_b;
    end else if (data_done && m_is_load) begin
      m_result <= data_rdata;
    end
  end

  // Writeback as M completes
  always_ff @(posedge clk) begin
    if (!stall) begin
      wb_value <= m_value;
      if (is_producer(m_instruction) && m_rd != '0) begin
        regs[m_rd] <= m_value;
      end
    end
  end

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          fetch_req,
  input  rv_pkg::word_t fetch_addr,
  output logic          fetch_done,
  output rv_pkg::word_t fetch_rdata,
  input  logic          data_req,
  input  logic          data_we,
  input  rv_pkg::word_t data_addr,
  input  rv_pkg::word_t data_wdata,
  output logic          data_done,
  output rv_pkg::word_t data_rdata,
  output logic          psel,
  output logic          penable,
  output logic          pwrite,
  output rv_pkg::word_t paddr,
  output rv_pkg::word_t pwdata,
  input  rv_pkg::word_t prdata,
  input  logic          pready
);
  import rv_pkg::*;

  arb_state_t state;
  logic       grant_data;
  logic       xfer_done;

  // --------------------------------------------------
  // Grant and APB phase FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ARB_IDLE;
      grant_data <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          // Data goes first, the M instruction is older
          if (data_req) begin
            grant_data <= 1'b1;
            state      <= ARB_SETUP;
          end else if (fetch_req) begin
            grant_data <= 1'b0;
            state      <= ARB_SETUP;
          end
        end
        ARB_SETUP: begin
          state <= ARB_ACCESS;
        end
        ARB_ACCESS: begin
          if (pready) begin
            state <= ARB_IDLE;
          end
        end
        default: begin
          state <= ARB_IDLE;
        end
      endcase
    end
  end

  assign psel      = (state != ARB_IDLE);
  assign penable   = (state == ARB_ACCESS);
  assign xfer_done = penable && pready;

  // Requesters hold their fields until done, so the bus stays stable
  assign paddr  = grant_data ? data_addr : fetch_addr;
  assign pwrite = grant_data && data_we;
  assign pwdata = grant_data ? data_wdata : '0;

  assign data_done   = xfer_done && grant_data;
  assign fetch_done  = xfer_done && !grant_data;
  assign data_rdata  = prdata;
  assign fetch_rdata = prdata;

endmodule

/* source/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top (
  input  logic          clk,
  input  logic          rst_n,
  output logic          psel,
  output logic          penable,
  output logic          pwrite,
  output rv_pkg::word_t paddr,
  output rv_pkg::word_t pwdata,
  input  rv_pkg::word_t prdata,
  input  logic          pready,
  output logic          halted
);
  import rv_pkg::*;

  // Fetch port
  logic     fetch_req;
  word_t    fetch_addr;
  logic     fetch_done;
  word_t    fetch_rdata;

  // Data port
  logic     data_req;
  logic     data_we;
  word_t    data_addr;
  word_t    data_wdata;
  logic     data_done;
  word_t    data_rdata;

  // Pipeline control
  logic     stall;
  logic     branch_taken;
  word_t    branch_target;

  // Stage contents
  word_t    fd_instruction;
  word_t    fd_pc;
  logic     fd_valid;
  word_t    x_instruction;
  word_t    m_instruction;
  fwd_sel_t a_forward_select;
  fwd_sel_t b_forward_select;

  // --------------------------------------------------
  // Blocks, port names match the wires above
  // --------------------------------------------------
  fetch_unit fetch_unit_i (.*);

  forwarding_logic forwarding_logic_i (.*);

  execute_stage execute_stage_i (.*);

  mem_arbiter mem_arbiter_i (.*);

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset held for 5 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;
  end

endmodule

/* dv/rv_core_assertions.sv */
`timescale 1ns/1ns

module rv_core_assertions (
  input logic             clk,
  input logic             rst_n,
  input logic             psel,
  input logic             penable,
  input logic             pwrite,
  input logic             pready,
  input rv_pkg::word_t    paddr,
  input rv_pkg::word_t    m_instruction,
  input rv_pkg::fwd_sel_t a_sel,
  input rv_pkg::fwd_sel_t b_sel
);
  import rv_pkg::*;

  int failures = 0;

  // --------------------------------------------------
  // APB protocol
  // --------------------------------------------------
  penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel)
    else begin
      $error("penable high without psel");
      failures++;
    end

  bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwrite)))
    else begin
      $error("paddr or pwrite changed during a transfer");
      failures++;
    end

  // One-cycle forward needs a real producer in M
  a_fwd_producer: assert property (@(posedge clk) disable iff (!rst_n)
    (a_sel == FWD_ONE_CYCLE) |-> (is_producer(m_instruction) && rd_of(m_instruction) != '0))
    else begin
      $error("operand A forwarded from a non-producer");
      failures++;
    end

  b_fwd_producer: assert property (@(posedge clk) disable iff (!rst_n)
    (b_sel == FWD_ONE_CYCLE) |-> (is_producer(m_instruction) && rd_of(m_instruction) != '0))
    else begin
      $error("operand B forwarded from a non-producer");
      failures++;
    end

endmodule

bind rv_core_top rv_core_assertions assertions_i (
  .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
  .pready(pready), .paddr(paddr), .m_instruction(m_instruction),
  .a_sel(a_forward_select), .b_sel(b_forward_select)
);

/* dv/rv_core_tb.sv */
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_core_tb;
  import rv_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  word_t       paddr;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        halted;
  word_t       mem [256];
  word_t       ref_mem [256];
  int unsigned waits;
  int          errors;
  int          cycles;

  tb_clock clock_i (.clk(clk), .rst_n(rst_n));

  rv_core_top dut_i (.*);

  function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, reg_idx_t rd, opcode_t opc);
    return {imm, rs1, (opc == `OPC_LOAD) ? 3'b010 : 3'b000, rd, opc};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  // --------------------------------------------------
  // Reference ISA model on its own copy of memory
  // --------------------------------------------------
  function automatic void run_reference();
    word_t x [32];
    word_t pc;
    word_t inst;
    word_t a;
    word_t b;
    word_t res;
    int    steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = `RV_RESET_PC;
    for (steps = 0; steps < 1000; steps++) begin
      inst = ref_mem[pc[9:2]];
      a    = x[inst[19:15]];
      b    = x[inst[24:20]];
      res  = '0;
      if (inst[6:0] == `OPC_SYSTEM) break;
      case (inst[6:0])
        `OPC_OP: begin
          case (inst[14:12])
            3'b000:  res = inst[30] ? a - b : a + b;
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            default: res = a & b;
          endcase
        end
        `OPC_OP_IMM: res = a + {{20{inst[31]}}, inst[31:20]};
        `OPC_LOAD:   res = ref_mem[(a + {{20{inst[31]}}, inst[31:20]}) >> 2];
        `OPC_STORE:  ref_mem[(a + {{20{inst[31]}}, inst[31:25], inst[11:7]}) >> 2] = b;
        default: ;
      endcase
      if (inst[6:0] == `OPC_BRANCH && a == b) begin
        pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end else begin
        pc = pc + 32'd4;
      end
      if (inst[6:0] != `OPC_STORE && inst[6:0] != `OPC_BRANCH && inst[11:7] != 5'd0) begin
        x[inst[11:7]] = res;
      end
    end
  endfunction

  // --------------------------------------------------
  // APB slave with 0 to 3 random wait states
  // --------------------------------------------------
  always @(posedge clk) begin
    #2;
    if (psel && !penable) begin
      waits  = $urandom % 4;
      pready = 1'b0;
    end else if (psel && penable && waits != 0) begin
      waits  = waits - 1;
      pready = 1'b0;
    end else begin
      pready = psel && penable;
    end
    prdata = mem[paddr[9:2]];
  end

  always @(negedge clk) begin
    if (psel && penable && pready && pwrite) mem[paddr[9:2]] = pwdata;
  end

  initial begin
    word_t prog [22];
    void'($urandom(32'h5f2f));
    pready = 1'b0;
    prdata = '0;
    errors = 0;
    prog[0]  = i_type(12'd5, 5'd0, 5'd1, `OPC_OP_IMM);
    prog[1]  = i_type(12'd3, 5'd1, 5'd2, `OPC_OP_IMM);
    prog[2]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
    prog[3]  = r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
    prog[4]  = i_type(12'd7, 5'd0, 5'd0, `OPC_OP_IMM);
    prog[5]  = r_type(7'h00, 5'd4, 5'd0, 3'b000, 5'd5);
    prog[6]  = r_type(7'h00, 5'd3, 5'd4, 3'b100, 5'd6);
    prog[7]  = s_type(12'h100, 5'd6, 5'd0);
    prog[8]  = r_type(7'h00, 5'd2, 5'd6, 3'b110, 5'd7);
    // Not taken, offset puts x7 in the rd field
    prog[9]  = b_type(13'h806, 5'd2, 5'd1);
    prog[10] = r_type(7'h00, 5'd3, 5'd7, 3'b111, 5'd8);
    prog[11] = s_type(12'h104, 5'd3, 5'd0);
    prog[12] = s_type(12'h108, 5'd5, 5'd0);
    prog[13] = i_type(12'h100, 5'd0, 5'd9, `OPC_LOAD);
    prog[14] = r_type(7'h00, 5'd1, 5'd9, 3'b000, 5'd10);
    prog[15] = s_type(12'h10c, 5'd10, 5'd0);
    prog[16] = s_type(12'h110, 5'd7, 5'd0);
    prog[17] = s_type(12'h114, 5'd8, 5'd0);
    prog[18] = b_type(13'd8, 5'd5, 5'd4);
    prog[19] = s_type(12'h118, 5'd1, 5'd0);
    prog[20] = s_type(12'h11c, 5'd4, 5'd0);
    prog[21] = 32'h0000_0073;
    for (int i = 0; i < 256; i++) begin
      mem[i] = (i < 22) ? prog[i] : (32'hc0de_0000 | (i * 32'h0001_0101));
      ref_mem[i] = mem[i];
    end
    run_reference();

    cycles = 0;
    while (!halted && cycles < 5000) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("The core did not halt within 5000 cycles");
      errors++;
    end
    for (int i = 0; i < 256; i++) begin
      if (mem[i] !== ref_mem[i]) begin
        $display("** Error mem[%h] expected %h actual %h", i * 4, ref_mem[i], mem[i]);
        errors++;
      end
    end
    $display("Checked 256 memory words, %0d errors, %0d assertion failures", errors,
             dut_i.assertions_i.failures);
    if (errors == 0 && dut_i.assertions_i.failures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+source
source/rv_pkg.sv
source/forwarding_logic.sv
source/fetch_unit.sv
source/execute_stage.sv
source/mem_arbiter.sv
source/rv_core_top.sv
dv/tb_clock.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
